// ==== replay_pkg.sv ====
package replay_pkg;

  // Queue layout
  localparam int num_queues = 4;
  localparam int qid_w      = 2;

  // Tag FIFO holds 8 entries, nearly full at 7
  localparam int tag_depth_bits = 3;

  // Output FIFO holds 32 word pairs per queue
  localparam int out_depth_bits = 5;

  // Leaves room for 8 reads in flight plus the return pipeline
  localparam int out_prog_full_level = 20;

  // Register map, one word per address
  localparam int reg_addr_w = 6;

  // Per-queue blocks, queue number added to the base
  localparam logic [reg_addr_w-1:0] reg_q_low_base   = 6'h00;
  localparam logic [reg_addr_w-1:0] reg_q_high_base  = 6'h04;
  localparam logic [reg_addr_w-1:0] reg_q_count_base = 6'h08;

  // Global masks and control
  localparam logic [reg_addr_w-1:0] reg_enable = 6'h10;
  localparam logic [reg_addr_w-1:0] reg_start  = 6'h11;
  // Bit 0 is the self-clearing software reset
  localparam logic [reg_addr_w-1:0] reg_ctrl   = 6'h12;

endpackage

// ==== replay_regs.sv ====
`timescale 1ns/100ps

module replay_regs #(
  parameter int addr_w  = 10,
  parameter int count_w = 16
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          reg_wr,
  input  logic [replay_pkg::reg_addr_w-1:0]             reg_addr,
  input  logic [31:0]                                   reg_wdata,
  input  logic [replay_pkg::num_queues-1:0]             done,
  output logic [replay_pkg::num_queues*addr_w-1:0]      q_low,
  output logic [replay_pkg::num_queues*addr_w-1:0]      q_high,
  output logic [replay_pkg::num_queues*count_w-1:0]     q_count,
  output logic [replay_pkg::num_queues-1:0]             q_enable,
  output logic [replay_pkg::num_queues-1:0]             q_start,
  output logic                                          sw_rst
);

  localparam int nq = replay_pkg::num_queues;
  localparam int aw = replay_pkg::reg_addr_w;

  logic wr_enable;
  logic wr_start;
  logic wr_ctrl;

  assign wr_enable = reg_wr && (reg_addr == replay_pkg::reg_enable);
  assign wr_start  = reg_wr && (reg_addr == replay_pkg::reg_start);
  assign wr_ctrl   = reg_wr && (reg_addr == replay_pkg::reg_ctrl);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_low    <= '0;
      q_high   <= '0;
      q_count  <= '0;
      q_enable <= '0;
      q_start  <= '0;
      sw_rst   <= 1'b0;
    end else begin
      // One-cycle pulse, starts the cycle after the strobe
      sw_rst <= wr_ctrl && reg_wdata[0];

      // Per-queue windows and replay counts
      for (int q = 0; q < nq; q++) begin
        if (reg_wr && (reg_addr == replay_pkg::reg_q_low_base + aw'(q))) begin
          q_low[q*addr_w +: addr_w] <= reg_wdata[addr_w-1:0];
        end
        if (reg_wr && (reg_addr == replay_pkg::reg_q_high_base + aw'(q))) begin
          q_high[q*addr_w +: addr_w] <= reg_wdata[addr_w-1:0];
        end
        if (reg_wr && (reg_addr == replay_pkg::reg_q_count_base + aw'(q))) begin
          q_count[q*count_w +: count_w] <= reg_wdata[count_w-1:0];
        end
      end

      if (wr_enable) begin
        q_enable <= reg_wdata[nq-1:0];
      end

      // A finished queue waits for software to start it again
      if (wr_start) begin
        q_start <= reg_wdata[nq-1:0];
      end else begin
        q_start <= q_start & ~done;
      end
    end
  end

endmodule

// ==== tag_fifo.sv ====
`timescale 1ns/100ps

module tag_fifo (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          clr,
  input  logic                          wr_en,
  input  logic [replay_pkg::qid_w-1:0]  din,
  input  logic                          rd_en,
  output logic [replay_pkg::qid_w-1:0]  dout,
  output logic                          empty,
  output logic                          nearly_full
);

  localparam int pw    = replay_pkg::tag_depth_bits;
  localparam int depth = 1 << pw;

  logic [replay_pkg::qid_w-1:0] mem [depth];
  logic [pw-1:0]                wr_ptr;
  logic [pw-1:0]                rd_ptr;
  logic [pw:0]                  count;
  logic                         push;
  logic                         pop;

  // Count MSB alone marks a full FIFO
  assign push        = wr_en && !count[pw];
  assign pop         = rd_en && !empty;
  assign empty       = (count == '0);
  assign nearly_full = (count >= (pw+1)'(depth - 1));

  // Head entry shows without a read
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clr) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== replay_mem_reader.sv ====
`timescale 1ns/100ps

module replay_mem_reader #(
  parameter int addr_w  = 10,
  parameter int data_w  = 18,
  parameter int count_w = 16
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       sw_rst,
  input  logic [replay_pkg::num_queues*addr_w-1:0]   q_low,
  input  logic [replay_pkg::num_queues*addr_w-1:0]   q_high,
  input  logic [replay_pkg::num_queues*count_w-1:0]  q_count,
  input  logic [replay_pkg::num_queues-1:0]          q_enable,
  input  logic [replay_pkg::num_queues-1:0]          q_start,
  input  logic [replay_pkg::num_queues-1:0]          out_prog_full,
  input  logic                                       mem_busy,
  input  logic                                       mem_rvalid,
  input  logic [data_w-1:0]                          mem_rdata_lo,
  input  logic [data_w-1:0]                          mem_rdata_hi,
  output logic                                       mem_rd,
  output logic [addr_w-1:0]                          mem_addr,
  output logic [replay_pkg::num_queues-1:0]          done,
  output logic [replay_pkg::num_queues-1:0]          out_wr,
  output logic [2*data_w-1:0]                        out_wdata
);

  localparam int nq = replay_pkg::num_queues;
  localparam int qw = replay_pkg::qid_w;

  logic [addr_w-1:0]  cur_addr [nq];
  logic [count_w-1:0] rem_cnt  [nq];
  logic [nq-1:0]      eligible;
  logic               grant_valid;
  logic [qw-1:0]      grant_q;
  logic [qw-1:0]      last_q;
  logic [qw-1:0]      last_eff;
  logic [qw-1:0]      cand;
  logic               pick_valid;
  logic [qw-1:0]      pick_q;
  logic               issue;
  logic [2:0]         drain_cnt;
  logic               drop;
  logic [qw-1:0]      tag_dout;
  logic               tag_empty;
  logic               tag_nearly_full;

  // A queue competes only with replays left and room downstream
  always_comb begin
    for (int q = 0; q < nq; q++) begin
      eligible[q] = q_enable[q] && q_start[q] && (rem_cnt[q] != '0) && !out_prog_full[q];
    end
  end

  // Returns from reads issued before a software reset are dropped
  assign drop = sw_rst || (drain_cnt != '0);

  // Pending grant is rechecked live and retried under back-pressure
  assign issue    = grant_valid && eligible[grant_q] && !mem_busy && !tag_nearly_full && !drop;
  assign mem_rd   = issue;
  assign mem_addr = cur_addr[grant_q];

  // Rotation starts after the queue served most recently
  assign last_eff = issue ? grant_q : last_q;

  always_comb begin
    pick_valid = 1'b0;
    pick_q     = last_eff;
    cand       = last_eff;
    // Walk from farthest to nearest so the nearest eligible wins
    for (int i = nq; i >= 1; i--) begin
      cand = last_eff + qw'(i);
      if (eligible[cand]) begin
        pick_valid = 1'b1;
        pick_q     = cand;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_valid <= 1'b0;
      grant_q     <= '0;
      last_q      <= qw'(nq - 1);
      drain_cnt   <= '0;
    end else if (sw_rst) begin
      grant_valid <= 1'b0;
      grant_q     <= '0;
      last_q      <= qw'(nq - 1);
      // Covers the longest memory latency
      drain_cnt   <= 3'd7;
    end else begin
      grant_valid <= pick_valid;
      grant_q     <= pick_q;
      if (issue) begin
        last_q <= grant_q;
      end
      if (drain_cnt != '0) begin
        drain_cnt <= drain_cnt - 1'b1;
      end
    end
  end

  // Per-queue address and replay counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int q = 0; q < nq; q++) begin
        cur_addr[q] <= '0;
        rem_cnt[q]  <= '0;
      end
      done <= '0;
    end else begin
      for (int q = 0; q < nq; q++) begin
        if (sw_rst || !q_enable[q]) begin
          // Configuration loads only while the queue is off
          cur_addr[q] <= q_low[q*addr_w +: addr_w];
          rem_cnt[q]  <= q_count[q*count_w +: count_w];
          done[q]     <= 1'b0;
        end else begin
          if (issue && (grant_q == qw'(q))) begin
            if ({1'b0, cur_addr[q]} + 1'b1 >= {1'b0, q_high[q*addr_w +: addr_w]}) begin
              cur_addr[q] <= q_low[q*addr_w +: addr_w];
              rem_cnt[q]  <= rem_cnt[q] - 1'b1;
            end else begin
              cur_addr[q] <= cur_addr[q] + 1'b1;
            end
          end
          // Sticky until the queue is disabled
          if (q_start[q] && (rem_cnt[q] == '0)) begin
            done[q] <= 1'b1;
          end
        end
      end
    end
  end

  tag_fifo u_tag_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr         (sw_rst),
    .wr_en       (issue),
    .din         (grant_q),
    .rd_en       (mem_rvalid && !drop),
    .dout        (tag_dout),
    .empty       (tag_empty),
    .nearly_full (tag_nearly_full)
  );

  // Steer the returned pair to the queue at the tag head
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_wr <= '0;
    end else begin
      out_wr <= '0;
      if (mem_rvalid && !drop && !tag_empty) begin
        out_wr[tag_dout] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rvalid) begin
      out_wdata <= {mem_rdata_hi, mem_rdata_lo};
    end
  end

endmodule

// ==== replay_out_fifo.sv ====
`timescale 1ns/100ps

module replay_out_fifo #(
  parameter int data_w = 18
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clr,
  input  logic                wr_en,
  input  logic [2*data_w-1:0] din,
  input  logic                rd_en,
  output logic [2*data_w-1:0] dout,
  output logic                empty,
  output logic                prog_full
);

  localparam int pw    = replay_pkg::out_depth_bits;
  localparam int depth = 1 << pw;

  logic [2*data_w-1:0] mem [depth];
  logic [pw-1:0]       wr_ptr;
  logic [pw-1:0]       rd_ptr;
  logic [pw:0]         count;
  logic                push;
  logic                pop;

  assign push      = wr_en && !count[pw];
  assign pop       = rd_en && !empty;
  assign empty     = (count == '0);
  assign prog_full = (count >= (pw+1)'(replay_pkg::out_prog_full_level));

  // Show-ahead read port
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clr) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== pcap_replay_top.sv ====
`timescale 1ns/100ps

module pcap_replay_top #(
  parameter int addr_w  = 10,
  parameter int data_w  = 18,
  parameter int count_w = 16
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         reg_wr,
  input  logic [replay_pkg::reg_addr_w-1:0]            reg_addr,
  input  logic [31:0]                                  reg_wdata,
  input  logic                                         mem_busy,
  input  logic                                         mem_rvalid,
  input  logic [data_w-1:0]                            mem_rdata_lo,
  input  logic [data_w-1:0]                            mem_rdata_hi,
  input  logic [replay_pkg::num_queues-1:0]            out_rd,
  output logic                                         mem_rd,
  output logic [addr_w-1:0]                            mem_addr,
  output logic [replay_pkg::num_queues*2*data_w-1:0]   out_data,
  output logic [replay_pkg::num_queues-1:0]            out_empty,
  output logic [replay_pkg::num_queues-1:0]            done
);

  localparam int nq = replay_pkg::num_queues;

  logic [nq*addr_w-1:0]  q_low;
  logic [nq*addr_w-1:0]  q_high;
  logic [nq*count_w-1:0] q_count;
  logic [nq-1:0]         q_enable;
  logic [nq-1:0]         q_start;
  logic                  sw_rst;
  logic [nq-1:0]         out_prog_full;
  logic [nq-1:0]         out_wr;
  logic [2*data_w-1:0]   out_wdata;

  replay_regs #(
    .addr_w  (addr_w),
    .count_w (count_w)
  ) u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .done      (done),
    .q_low     (q_low),
    .q_high    (q_high),
    .q_count   (q_count),
    .q_enable  (q_enable),
    .q_start   (q_start),
    .sw_rst    (sw_rst)
  );

  replay_mem_reader #(
    .addr_w  (addr_w),
    .data_w  (data_w),
    .count_w (count_w)
  ) u_reader (
    .clk           (clk),
    .rst_n         (rst_n),
    .sw_rst        (sw_rst),
    .q_low         (q_low),
    .q_high        (q_high),
    .q_count       (q_count),
    .q_enable      (q_enable),
    .q_start       (q_start),
    .out_prog_full (out_prog_full),
    .mem_busy      (mem_busy),
    .mem_rvalid    (mem_rvalid),
    .mem_rdata_lo  (mem_rdata_lo),
    .mem_rdata_hi  (mem_rdata_hi),
    .mem_rd        (mem_rd),
    .mem_addr      (mem_addr),
    .done          (done),
    .out_wr        (out_wr),
    .out_wdata     (out_wdata)
  );

  // One output FIFO per queue, sharing the write data bus
  for (genvar q = 0; q < nq; q++) begin : g_out
    replay_out_fifo #(
      .data_w (data_w)
    ) u_out_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .clr       (sw_rst),
      .wr_en     (out_wr[q]),
      .din       (out_wdata),
      .rd_en     (out_rd[q]),
      .dout      (out_data[q*2*data_w +: 2*data_w]),
      .empty     (out_empty[q]),
      .prog_full (out_prog_full[q])
    );
  end

endmodule

// ==== tb_sram_model.sv ====
`timescale 1ns/100ps

module tb_sram_model #(
  parameter int addr_w = 10,
  parameter int data_w = 18
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mem_rd,
  input  logic [addr_w-1:0] mem_addr,
  output logic              mem_busy,
  output logic              mem_rvalid,
  output logic [data_w-1:0] mem_rdata_lo,
  output logic [data_w-1:0] mem_rdata_hi
);

  // Reads waiting to return in issue order
  int pend_addr[$];
  int pend_due[$];
  int cycle;
  int last_due;
  int lat;
  int due;

  // Bus idle until the first clock edge
  initial begin
    mem_busy     <= 1'b0;
    mem_rvalid   <= 1'b0;
    mem_rdata_lo <= '0;
    mem_rdata_hi <= '0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_busy     <= 1'b0;
      mem_rvalid   <= 1'b0;
      mem_rdata_lo <= '0;
      mem_rdata_hi <= '0;
      cycle        = 0;
      last_due     = 0;
      pend_addr.delete();
      pend_due.delete();
    end else begin
      cycle = cycle + 1;
      // Busy roughly one cycle in five
      mem_busy <= (($urandom % 5) == 0);
      if (mem_rd) begin
        lat = 2 + int'($urandom % 5);
        due = cycle + lat - 1;
        // Returns never overtake an older read
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(int'(mem_addr));
        pend_due.push_back(due);
      end
      mem_rvalid <= 1'b0;
      if (pend_due.size() > 0 && pend_due[0] == cycle) begin
        mem_rvalid   <= 1'b1;
        mem_rdata_lo <= data_w'(pend_addr[0]);
        mem_rdata_hi <= data_w'(pend_addr[0] + 32'h15000);
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
    end
  end

endmodule

// ==== tb_pcap_replay.sv ====
`timescale 1ns/100ps

module tb_pcap_replay;

  localparam int addr_w     = 10;
  localparam int data_w     = 18;
  localparam int count_w    = 16;
  localparam int nq         = replay_pkg::num_queues;
  localparam int pair_w     = 2 * data_w;
  localparam int max_cycles = 20000;

  logic                   clk = 1'b0;
  logic                   rst_n = 1'b0;
  logic                   reg_wr = 1'b0;
  logic [5:0]             reg_addr = '0;
  logic [31:0]            reg_wdata = '0;
  logic [nq-1:0]          out_rd = '0;
  logic                   mem_busy;
  logic                   mem_rvalid;
  logic [data_w-1:0]      mem_rdata_lo;
  logic [data_w-1:0]      mem_rdata_hi;
  logic                   mem_rd;
  logic [addr_w-1:0]      mem_addr;
  logic [nq*pair_w-1:0]   out_data;
  logic [nq-1:0]          out_empty;
  logic [nq-1:0]          done;

  // Reference state written by the stimulus process
  int            win_lo[nq];
  int            win_len[nq];
  int            exp_total[nq];
  int            rx_cnt[nq];
  int            issued[nq];
  logic [nq-1:0] en_sh = '0;
  logic [nq-1:0] st_sh = '0;
  logic          drain_en = 1'b0;
  logic [nq-1:0] hold_mask = '0;
  logic          count_clr = 1'b0;
  int            cycles = 0;

  pcap_replay_top #(
    .addr_w  (addr_w),
    .data_w  (data_w),
    .count_w (count_w)
  ) UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .reg_wr       (reg_wr),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .mem_busy     (mem_busy),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata_lo (mem_rdata_lo),
    .mem_rdata_hi (mem_rdata_hi),
    .out_rd       (out_rd),
    .mem_rd       (mem_rd),
    .mem_addr     (mem_addr),
    .out_data     (out_data),
    .out_empty    (out_empty),
    .done         (done)
  );

  tb_sram_model #(
    .addr_w (addr_w),
    .data_w (data_w)
  ) u_sram (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_rd       (mem_rd),
    .mem_addr     (mem_addr),
    .mem_busy     (mem_busy),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata_lo (mem_rdata_lo),
    .mem_rdata_hi (mem_rdata_hi)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Simulation timed out after %0d cycles", max_cycles);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "check failed");
  endtask

  // SRAM word pair at address a is {a + 0x15000, a}
  function automatic logic [pair_w-1:0] expected_pair(input int q, input int idx);
    int a;
    a = win_lo[q] + (idx % win_len[q]);
    return {data_w'(a + 32'h15000), data_w'(a)};
  endfunction

  // Random draining that skips held queues
  always @(posedge clk) begin
    out_rd <= 4'($urandom) & ~hold_mask & {nq{drain_en}};
  end

  always @(posedge clk) begin : monitor
    int                owner;
    logic [pair_w-1:0] got;
    if (!rst_n || count_clr) begin
      for (int q = 0; q < nq; q++) begin
        rx_cnt[q] = 0;
        issued[q] = 0;
      end
    end else begin
      for (int q = 0; q < nq; q++) begin
        if (done[q]) begin
          assert (issued[q] == exp_total[q]) else
            report_error($sformatf("queue %0d done after %0d of %0d reads",
                                   q, issued[q], exp_total[q]));
        end
        if (out_rd[q] && !out_empty[q]) begin
          assert (rx_cnt[q] < exp_total[q]) else
            report_error($sformatf("queue %0d output an extra word", q));
          got = out_data[q*pair_w +: pair_w];
          assert (got == expected_pair(q, rx_cnt[q])) else
            report_error($sformatf("queue %0d word %0d is %h, expected %h",
                                   q, rx_cnt[q], got, expected_pair(q, rx_cnt[q])));
          rx_cnt[q] = rx_cnt[q] + 1;
        end
      end
      if (mem_rd) begin
        assert (!mem_busy) else report_error("mem_rd issued while mem_busy high");
        owner = -1;
        for (int q = 0; q < nq; q++) begin
          if (int'(mem_addr) >= win_lo[q] && int'(mem_addr) < win_lo[q] + win_len[q]) begin
            owner = q;
          end
        end
        assert (owner >= 0 && en_sh[owner] && st_sh[owner]) else
          report_error($sformatf("read at %h outside every active window", mem_addr));
        if (owner >= 0) begin
          issued[owner] = issued[owner] + 1;
        end
      end
    end
    // Shadow of the enable and start masks
    if (reg_wr && reg_addr == replay_pkg::reg_enable) begin
      en_sh = reg_wdata[nq-1:0];
    end
    if (reg_wr && reg_addr == replay_pkg::reg_start) begin
      st_sh = reg_wdata[nq-1:0];
    end
  end

  task automatic write_reg(input logic [5:0] addr, input logic [31:0] data);
    @(posedge clk);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_wr    <= 1'b0;
  endtask

  task automatic clear_counts();
    @(posedge clk);
    count_clr <= 1'b1;
    @(posedge clk);
    count_clr <= 1'b0;
  endtask

  // Disable, load random windows and counts, then start and enable
  task automatic program_phase(input logic [nq-1:0] en, input logic [nq-1:0] st,
                               input logic long_q0);
    int lo;
    int len;
    int cnt;
    write_reg(replay_pkg::reg_enable, 32'h0);
    repeat (3) @(posedge clk);
    for (int q = 0; q < nq; q++) begin
      len = 1 + int'($urandom % 12);
      lo  = q * 64 + int'($urandom % 40);
      cnt = 1 + int'($urandom % 4);
      if (long_q0 && q == 0) begin
        len = 12;
        cnt = 4;
      end
      win_lo[q]    <= lo;
      win_len[q]   <= len;
      exp_total[q] <= (en[q] && st[q]) ? len * cnt : 0;
      write_reg(replay_pkg::reg_q_low_base + 6'(q), 32'(lo));
      write_reg(replay_pkg::reg_q_high_base + 6'(q), 32'(lo + len));
      write_reg(replay_pkg::reg_q_count_base + 6'(q), 32'(cnt));
    end
    clear_counts();
    write_reg(replay_pkg::reg_start, 32'(st));
    write_reg(replay_pkg::reg_enable, 32'(en));
  endtask

  // Wait for the done flags and a full drain, then confirm nothing trails
  task automatic finish_phase(input logic [nq-1:0] act);
    logic all_in;
    all_in = 1'b0;
    while (!all_in) begin
      @(negedge clk);
      all_in = (done == act) && (out_empty == '1);
      for (int q = 0; q < nq; q++) begin
        if (rx_cnt[q] != exp_total[q]) begin
          all_in = 1'b0;
        end
      end
    end
    repeat (20) @(posedge clk);
    @(negedge clk);
    assert (out_empty == '1 && done == act) else
      report_error($sformatf("after drain out_empty %b done %b", out_empty, done));
  endtask

  initial begin
    void'($urandom(32'hae4c));
    for (int q = 0; q < nq; q++) begin
      win_lo[q]    = 0;
      win_len[q]   = 0;
      exp_total[q] = 0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!mem_rd && out_empty == '1 && done == '0) else
      report_error("outputs not idle after reset");
    @(posedge clk);
    drain_en <= 1'b1;

    // All queues under memory back-pressure
    program_phase(4'hF, 4'hF, 1'b0);
    finish_phase(4'hF);

    // Queue 2 started only and queue 3 enabled only
    program_phase(4'b1011, 4'b0111, 1'b0);
    finish_phase(4'b0011);

    // Queue 0 held full while the rest run
    hold_mask <= 4'b0001;
    program_phase(4'hF, 4'hF, 1'b1);
    repeat (600) @(posedge clk);
    @(negedge clk);
    assert (done == 4'b1110) else
      report_error($sformatf("done %b while queue 0 held", done));
    @(posedge clk);
    hold_mask <= 4'b0000;
    finish_phase(4'hF);

    // Software reset mid-replay followed by a full restart
    program_phase(4'hF, 4'hF, 1'b1);
    repeat (40) @(posedge clk);
    drain_en <= 1'b0;
    // Wait for a word to sit in an output FIFO once draining stops
    @(posedge clk);
    @(negedge clk);
    while (out_empty == '1) begin
      @(negedge clk);
    end
    write_reg(replay_pkg::reg_enable, 32'h0);
    write_reg(replay_pkg::reg_ctrl, 32'h1);
    repeat (12) @(posedge clk);
    @(negedge clk);
    assert (out_empty == '1) else
      report_error($sformatf("out_empty %b after software reset", out_empty));
    clear_counts();
    write_reg(replay_pkg::reg_start, 32'hF);
    write_reg(replay_pkg::reg_enable, 32'hF);
    drain_en <= 1'b1;
    finish_phase(4'hF);

    program_phase(4'hF, 4'hF, 1'b0);
    finish_phase(4'hF);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
replay_pkg.sv
replay_regs.sv
tag_fifo.sv
replay_mem_reader.sv
replay_out_fifo.sv
pcap_replay_top.sv
tb_sram_model.sv
tb_pcap_replay.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the replay engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module tb_pcap_replay -o sim_tb

./obj_dir/sim_tb
